/* tb.f */
+incdir+common
common/cim_pkg.sv
common/obuf_if.sv
common/ibuf_wr_if.sv
hw/cim_obuf_bank.sv
fc_func/fc_func.sv
hw/ibuf_next.sv
hw/mlp_layer_top.sv
bench/tb_mlp_layer.sv

/* run.sh */
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/10ps \
    --top-module tb_mlp_layer -f tb.f -o tb_mlp_layer \
    && ./obj_dir/tb_mlp_layer \
    || exit 1

/* bench/tb_mlp_layer.sv */
// Testbench tb_mlp_layer with clock, reset, APB tasks, reference model, stimulus and checks
`timescale 1ns/10ps
`include "cim_defines.svh"

module tb_mlp_layer;
    import cim_pkg::*;

    localparam int WAIT_LIMIT = 40; // Cycles allowed per wait loop

    logic clk = 1'b0;
    logic rst;
    logic i_psel;
    logic i_penable;
    logic i_pwrite;
    logic [`APB_ADDR_W-1:0] i_paddr;
    logic [`APB_DATA_W-1:0] i_pwdata;
    logic [`APB_DATA_W-1:0] o_prdata;
    logic o_pready;
    logic o_pslverr;
    logic i_start;
    logic o_ready;
    logic o_cim_ready;
    logic i_release;
    logic [`IBUF_RD_ADDR_W-1:0] i_rd_addr;
    t_act o_rd_data;
    logic o_ibuf_full;

    int seed = 32'ha2b59a93;
    int psum_model [`NUM_PSUM]; // Sign-extended sums as stored
    int low_run; // Consecutive cycles with o_ready low

    always #2 clk = ~clk; // 4 ns period

    mlp_layer_top mlp_layer_top_inst (.*);

    always @(posedge clk) begin
        if (rst || o_ready) begin
            low_run <= 0;
        end else begin
            low_run <= low_run + 1;
        end
    end

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1, "Simulation stopped at first error");
    endtask

    task automatic check_value(input string name, input int expected, input int actual);
        assert (expected == actual)
            else fail_now($sformatf("FAIL %s expected %0d got %0d", name, expected, actual));
    endtask

    // Low OBUF_DATA_SIZE bits of an APB word, as the bank keeps them
    function automatic int sext_psum(input logic [31:0] word);
        logic signed [`OBUF_DATA_SIZE-1:0] p;
        p = word[`OBUF_DATA_SIZE-1:0];
        return int'(p);
    endfunction

    function automatic int expected_byte(input int a, input int h, input int c);
        int sum;
        sum = 0;
        for (int v = 0; v < `V_CIM_TILES; v++) begin
            sum += psum_model[((a * `H_CIM_TILES + h) * `NUM_CHANNELS + c) * `V_CIM_TILES + v];
        end
        return (sum < 0) ? 0 : (sum & 'hff); // ReLU then keep one byte
    endfunction

    task automatic apb_transfer(input logic write, input int addr, input logic [31:0] wdata,
                                input logic exp_err, output logic [31:0] rdata);
        @(posedge clk);
        i_psel <= 1'b1;
        i_penable <= 1'b0;
        i_pwrite <= write;
        i_paddr <= addr[`APB_ADDR_W-1:0];
        i_pwdata <= wdata;
        @(posedge clk);
        i_penable <= 1'b1; // Access phase
        @(negedge clk);
        check_value($sformatf("apb_pready_%0h", addr), 1, o_pready);
        check_value($sformatf("apb_pslverr_%0h", addr), exp_err, o_pslverr);
        rdata = o_prdata;
        @(posedge clk);
        i_psel <= 1'b0;
        i_penable <= 1'b0;
        i_pwrite <= 1'b0;
    endtask

    // Start stays asserted on return
    task automatic hold_start(input int cycles, input logic exp_cim, input logic exp_full);
        @(posedge clk);
        i_start <= 1'b1;
        repeat (cycles) begin
            @(negedge clk);
            check_value("refused_ready", 1, o_ready);
            check_value("refused_cim_ready", exp_cim, o_cim_ready);
            check_value("refused_full", exp_full, o_ibuf_full);
        end
    endtask

    task automatic run_layer();
        int n;
        @(posedge clk);
        i_start <= 1'b1;
        for (n = 0; n < WAIT_LIMIT && o_ready; n++) begin
            @(negedge clk);
        end
        if (o_ready) fail_now("Timeout: start was never accepted");
        @(posedge clk);
        i_start <= 1'b0;
        for (n = 0; n < WAIT_LIMIT && !o_ibuf_full; n++) begin
            @(negedge clk);
        end
        if (!o_ibuf_full) fail_now("Timeout: input buffer never became full");
        check_value("cim_ready_after_layer", 0, o_cim_ready);
    endtask

    task automatic check_results();
        int idx;
        for (int a = 0; a < `NUM_ADDR; a++) begin
            for (int h = 0; h < `H_CIM_TILES; h++) begin
                for (int c = 0; c < `NUM_CHANNELS; c++) begin
                    idx = (a * `H_CIM_TILES + h) * `NUM_CHANNELS + c;
                    @(posedge clk);
                    i_rd_addr <= idx[`IBUF_RD_ADDR_W-1:0];
                    @(negedge clk);
                    check_value($sformatf("relu_byte_%0d", idx), expected_byte(a, h, c),
                                int'(o_rd_data));
                end
            end
        end
    endtask

    a_accept_timing: assert property (@(posedge clk) disable iff (rst)
        o_ready && i_start && o_cim_ready && !o_ibuf_full
        |=> !o_ready ##(`NUM_ADDR) ($rose(o_ibuf_full) && $fell(o_cim_ready)))
        else fail_now($sformatf("FAIL accept_timing expected full=1 cim_ready=0 got %0b %0b",
                                o_ibuf_full, o_cim_ready));

    a_back_pressure: assert property (@(posedge clk) disable iff (rst)
        o_ready && i_start && !(o_cim_ready && !o_ibuf_full) |=> o_ready)
        else fail_now($sformatf("FAIL back_pressure expected ready 1 got %0b", o_ready));

    a_ready_low_len: assert property (@(posedge clk) disable iff (rst)
        $rose(o_ready) |-> low_run == `NUM_ADDR)
        else fail_now($sformatf("FAIL ready_low_cycles expected %0d got %0d",
                                `NUM_ADDR, low_run));

    initial begin
        logic [31:0] rdata;
        logic [31:0] word;
        rst = 1'b1;
        i_psel = 1'b0;
        i_penable = 1'b0;
        i_pwrite = 1'b0;
        i_paddr = '0;
        i_pwdata = '0;
        i_start = 1'b0;
        i_release = 1'b0;
        i_rd_addr = '0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_value("reset_ready", 1, o_ready);
        check_value("reset_cim_ready", 0, o_cim_ready);
        check_value("reset_full", 0, o_ibuf_full);

        // Fixed corner sums before random ones of both signs
        for (int i = 0; i < `NUM_PSUM; i++) begin
            word = $random(seed);
            if (i == 0) word = -5; // Negative sum gives 0
            if (i == 1) word = -3;
            if (i == 2) word = 300; // 310 truncates to 54
            if (i == 3) word = 10;
            if (i == 4) word = 32'h7fff_ffff; // Truncated to -1
            psum_model[i] = sext_psum(word);
            apb_transfer(1'b1, i, word, 1'b0, rdata);
        end
        for (int i = 0; i < `NUM_PSUM; i++) begin
            apb_transfer(1'b0, i, '0, 1'b0, rdata);
            check_value($sformatf("apb_readback_%0d", i), psum_model[i], int'(rdata));
        end
        apb_transfer(1'b1, 'h050, 32'h1234, 1'b1, rdata);
        apb_transfer(1'b0, 'h3ff, '0, 1'b1, rdata);

        hold_start(5, 1'b0, 1'b0); // No load-done yet
        @(posedge clk);
        i_start <= 1'b0;
        apb_transfer(1'b1, `CIM_CTRL_ADDR, 32'h1, 1'b0, rdata);
        @(negedge clk);
        check_value("load_done", 1, o_cim_ready);
        run_layer();
        check_results();

        // Fresh sums for the second layer
        for (int i = 0; i < `NUM_PSUM; i++) begin
            word = $random(seed);
            psum_model[i] = sext_psum(word);
            apb_transfer(1'b1, i, word, 1'b0, rdata);
        end
        apb_transfer(1'b1, `CIM_CTRL_ADDR, 32'h1, 1'b0, rdata);
        hold_start(5, 1'b1, 1'b1); // Buffer still full
        @(posedge clk);
        i_release <= 1'b1;
        @(posedge clk);
        i_release <= 1'b0;
        run_layer();
        check_results();

        $display("Done: no errors");
        $finish;
    end

endmodule

/* hw/mlp_layer_top.sv */
// Module mlp_layer_top with the obuf bank, fc_func and next-layer ibuf wired together
`timescale 1ns/10ps
`include "cim_defines.svh"

module mlp_layer_top (
    input  logic clk,
    input  logic rst,

    // Host APB to the tile output buffers
    input  logic i_psel,
    input  logic i_penable,
    input  logic i_pwrite,
    input  logic [`APB_ADDR_W-1:0] i_paddr,
    input  logic [`APB_DATA_W-1:0] i_pwdata,
    output logic [`APB_DATA_W-1:0] o_prdata,
    output logic o_pready,
    output logic o_pslverr,

    // Previous stage handshake
    input  logic i_start,
    output logic o_ready,
    output logic o_cim_ready,

    // Host side of the next-layer buffer
    input  logic i_release,
    input  logic [`IBUF_RD_ADDR_W-1:0] i_rd_addr,
    output cim_pkg::t_act o_rd_data,
    output logic o_ibuf_full
);

    obuf_if obuf_bus ();
    ibuf_wr_if ibuf_bus ();

    assign o_cim_ready = obuf_bus.cim_ready;

    cim_obuf_bank cim_obuf_bank_inst (
        .clk       (clk),
        .rst       (rst),
        .i_psel    (i_psel),
        .i_penable (i_penable),
        .i_pwrite  (i_pwrite),
        .i_paddr   (i_paddr),
        .i_pwdata  (i_pwdata),
        .o_prdata  (o_prdata),
        .o_pready  (o_pready),
        .o_pslverr (o_pslverr),
        .obuf      (obuf_bus.bank)
    );

    fc_func fc_func_inst (
        .clk     (clk),
        .rst     (rst),
        .i_start (i_start),
        .o_ready (o_ready),
        .obuf    (obuf_bus.func),
        .wr      (ibuf_bus.func)
    );

    ibuf_next ibuf_next_inst (
        .clk       (clk),
        .rst       (rst),
        .wr        (ibuf_bus.ibuf),
        .i_release (i_release),
        .i_rd_addr (i_rd_addr),
        .o_rd_data (o_rd_data),
        .o_full    (o_ibuf_full)
    );

endmodule

/* hw/ibuf_next.sv */
// Module ibuf_next with the next-layer input buffer, write pointer, full flag and host read
`timescale 1ns/10ps
`include "cim_defines.svh"

module ibuf_next (
    input  logic clk,
    input  logic rst,

    ibuf_wr_if.ibuf wr,

    // Host side
    input  logic i_release, // Clears full
    input  logic [`IBUF_RD_ADDR_W-1:0] i_rd_addr,
    output cim_pkg::t_act o_rd_data,
    output logic o_full
);
    import cim_pkg::*;

    localparam int ROW_BYTES = `H_CIM_TILES * `NUM_CHANNELS;

    t_act_row rows [`NUM_ADDR];
    logic [`OBUF_ADDR_W-1:0] wr_ptr;
    logic full;

    assign wr.next_ready = !full;
    assign o_full = full;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            full <= 1'b0;
        end else begin
            if (wr.write_enable) begin
                wr_ptr <= wr.start ? '0 : wr_ptr + 1'b1; // Rewind after last row
            end
            if (wr.start) begin
                full <= 1'b1;
            end else if (i_release) begin
                full <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr.write_enable) begin
            rows[wr_ptr] <= wr.data;
        end
    end

    // Byte index is (row*H + h)*CH + c
    always_comb begin
        int row;
        int h;
        int c;
        row = int'(i_rd_addr) / ROW_BYTES;
        h = (int'(i_rd_addr) % ROW_BYTES) / `NUM_CHANNELS;
        c = int'(i_rd_addr) % `NUM_CHANNELS;
        o_rd_data = rows[row][h][c];
    end

    // fc_func must respect next_ready
    a_no_write_when_full: assert property (@(posedge clk) disable iff (rst)
        wr.write_enable |-> !full);

endmodule

/* fc_func/fc_func.sv */
// Module fc_func with vertical tile accumulation, ReLU and idle/busy address sequencing
`timescale 1ns/10ps
`include "cim_defines.svh"

module fc_func (
    input  logic clk,
    input  logic rst,

    // Previous stage handshake
    input  logic i_start,
    output logic o_ready,

    obuf_if.func obuf,
    ibuf_wr_if.func wr
);
    import cim_pkg::*;

    // One extra bit per doubling of summed tiles
    localparam int ACC_W = `OBUF_DATA_SIZE + $clog2(`V_CIM_TILES);

    t_func_state state;
    t_func_state next_state;
    logic [`OBUF_ADDR_W-1:0] addr;
    logic [`OBUF_ADDR_W-1:0] next_addr;
    logic last_addr;
    logic signed [ACC_W-1:0] acc [`H_CIM_TILES][`NUM_CHANNELS];

    assign obuf.addr = addr;
    assign last_addr = addr == `OBUF_ADDR_W'(`NUM_ADDR - 1);

    // Sum the vertical tiles then ReLU with truncation to a byte
    always_comb begin
        for (int h = 0; h < `H_CIM_TILES; h++) begin
            for (int c = 0; c < `NUM_CHANNELS; c++) begin
                acc[h][c] = '0;
                for (int v = 0; v < `V_CIM_TILES; v++) begin
                    acc[h][c] = acc[h][c] + $signed(obuf.data[h][c][v]); // Sign-extends
                end
                if (acc[h][c][ACC_W-1]) begin
                    wr.data[h][c] = '0; // Negative sum
                end else begin
                    wr.data[h][c] = acc[h][c][`DATA_SIZE-1:0];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= s_func_idle;
            addr <= '0;
        end else begin
            state <= next_state;
            addr <= next_addr;
        end
    end

    always_comb begin
        next_state = state;
        next_addr = '0;
        o_ready = 1'b0;
        wr.write_enable = 1'b0;
        wr.start = 1'b0;
        obuf.done = 1'b0;
        case (state)
            s_func_idle: begin
                o_ready = 1'b1;
                // Back-pressure holds start until both sides are ready
                if (i_start && obuf.cim_ready && wr.next_ready) begin
                    next_state = s_func_busy;
                end
            end
            s_func_busy: begin
                wr.write_enable = 1'b1;
                next_addr = addr + 1'b1;
                if (last_addr) begin
                    wr.start = 1'b1; // Hand layer to next stage
                    obuf.done = 1'b1;
                    next_addr = '0;
                    next_state = s_func_idle;
                end
            end
            default: begin
                next_state = s_func_idle;
            end
        endcase
    end

    a_addr_range: assert property (@(posedge clk) disable iff (rst)
        state == s_func_busy |-> int'(obuf.addr) < `NUM_ADDR);

    // Writes happen only in busy while the bank still holds valid sums
    a_write_in_busy: assert property (@(posedge clk) disable iff (rst)
        wr.write_enable |-> state == s_func_busy && obuf.cim_ready);

endmodule

/* hw/cim_obuf_bank.sv */
// Module cim_obuf_bank with APB-loaded partial sum storage and a combinational row read
`timescale 1ns/10ps
`include "cim_defines.svh"

module cim_obuf_bank (
    input  logic clk,
    input  logic rst,

    // Host APB with paddr as a word index
    input  logic i_psel,
    input  logic i_penable,
    input  logic i_pwrite,
    input  logic [`APB_ADDR_W-1:0] i_paddr,
    input  logic [`APB_DATA_W-1:0] i_pwdata,
    output logic [`APB_DATA_W-1:0] o_prdata,
    output logic o_pready,
    output logic o_pslverr,

    obuf_if.bank obuf
);
    import cim_pkg::*;

    localparam int PSUM_IDX_W = $clog2(`NUM_PSUM);

    t_psum mem [`NUM_PSUM]; // Index ((addr*H+h)*CH+c)*V+v

    logic access;
    logic mem_hit;
    logic ctrl_hit;
    logic [PSUM_IDX_W-1:0] psum_idx;
    logic signed [`APB_DATA_W-1:0] rd_ext;
    logic cim_ready;

    assign access = i_psel && i_penable;
    assign mem_hit = i_paddr < `APB_ADDR_W'(`NUM_PSUM);
    assign ctrl_hit = i_paddr == `APB_ADDR_W'(`CIM_CTRL_ADDR);
    assign psum_idx = i_paddr[PSUM_IDX_W-1:0];

    assign o_pready = 1'b1; // No wait states
    assign o_pslverr = access && !mem_hit && !ctrl_hit;

    // Host read mux with sign-extended partial sums
    always_comb begin
        rd_ext = mem[psum_idx];
        if (mem_hit) begin
            o_prdata = rd_ext;
        end else if (ctrl_hit) begin
            o_prdata = {{(`APB_DATA_W-1){1'b0}}, cim_ready};
        end else begin
            o_prdata = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (access && i_pwrite && mem_hit) begin
            mem[psum_idx] <= i_pwdata[`OBUF_DATA_SIZE-1:0]; // Truncate to psum width
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cim_ready <= 1'b0;
        end else if (obuf.done) begin
            cim_ready <= 1'b0; // Layer consumed
        end else if (access && i_pwrite && ctrl_hit && i_pwdata[0]) begin
            cim_ready <= 1'b1;
        end
    end

    assign obuf.cim_ready = cim_ready;

    // Row presented to fc_func for the current address
    always_comb begin
        for (int h = 0; h < `H_CIM_TILES; h++) begin
            for (int c = 0; c < `NUM_CHANNELS; c++) begin
                for (int v = 0; v < `V_CIM_TILES; v++) begin
                    obuf.data[h][c][v] = mem[((int'(obuf.addr) * `H_CIM_TILES + h)
                        * `NUM_CHANNELS + c) * `V_CIM_TILES + v];
                end
            end
        end
    end

    // Host must not set load-done while a layer finishes
    a_no_load_on_done: assert property (@(posedge clk) disable iff (rst)
        obuf.done |-> !(access && i_pwrite && ctrl_hit && i_pwdata[0]));

endmodule

/* common/ibuf_wr_if.sv */
// Interface ibuf_wr_if between the function unit and the next-layer input buffer
`timescale 1ns/10ps

interface ibuf_wr_if;
    import cim_pkg::*;

    t_act_row data; // ReLU bytes for one address
    logic write_enable;
    logic next_ready; // Buffer not full
    logic start; // Last write of the layer

    modport func (
        output data,
        output write_enable,
        output start,
        input  next_ready
    );

    modport ibuf (
        input  data,
        input  write_enable,
        input  start,
        output next_ready
    );

endinterface

/* common/obuf_if.sv */
// Interface obuf_if between the output buffer bank and the function unit
`timescale 1ns/10ps
`include "cim_defines.svh"

interface obuf_if;
    import cim_pkg::*;

    logic [`OBUF_ADDR_W-1:0] addr; // Read address from fc_func
    t_psum_row data; // Combinational read of addr
    logic cim_ready; // Partial sums loaded
    logic done; // Layer drained, clears cim_ready

    modport bank (
        input  addr,
        input  done,
        output data,
        output cim_ready
    );

    modport func (
        output addr,
        output done,
        input  data,
        input  cim_ready
    );

endinterface

/* common/cim_pkg.sv */
// Package cim_pkg with the function unit state enum and partial sum / activation types
`include "cim_defines.svh"

package cim_pkg;

    typedef enum logic {
        s_func_idle, // Waiting for start
        s_func_busy // Draining obuf into ibuf
    } t_func_state;

    // One partial sum from a tile output buffer
    typedef logic signed [`OBUF_DATA_SIZE-1:0] t_psum;

    // One activation byte for the next layer
    typedef logic [`DATA_SIZE-1:0] t_act;

    // All partial sums at one obuf address
    typedef t_psum [`H_CIM_TILES-1:0][`NUM_CHANNELS-1:0][`V_CIM_TILES-1:0] t_psum_row;

    // All activations produced from one obuf address
    typedef t_act [`H_CIM_TILES-1:0][`NUM_CHANNELS-1:0] t_act_row;

endpackage

/* common/cim_defines.svh */
// Layer geometry, partial sum width and APB bus sizes for the CIM layer stage
`ifndef CIM_DEFINES_SVH
`define CIM_DEFINES_SVH

`define DATA_SIZE 8 // Activation byte
`define XBAR_SIZE 32 // Crossbar rows per tile
`define H_CIM_TILES 2
`define V_CIM_TILES 2 // Tiles summed per output
`define NUM_CHANNELS 2 // Elements read in parallel per tile
`define NUM_ADDR 2 // Obuf addresses per layer

// Product of two bytes plus growth over the crossbar rows
`define OBUF_DATA_SIZE (2*`DATA_SIZE+$clog2(`XBAR_SIZE))

`define OBUF_ADDR_W ($clog2(`NUM_ADDR))
`define NUM_PSUM (`NUM_ADDR*`H_CIM_TILES*`NUM_CHANNELS*`V_CIM_TILES)
`define IBUF_RD_ADDR_W ($clog2(`NUM_ADDR*`H_CIM_TILES*`NUM_CHANNELS))

`define APB_ADDR_W 12
`define APB_DATA_W 32
`define CIM_CTRL_ADDR 'h100 // Load-done register, word address

`endif
